/* src/mc_mem_pkg.sv */
package mc_mem_pkg;

  // requesters sharing the single dram channel
  localparam int num_vcaches_lp = 4;
  localparam int vcache_id_width_lp = $clog2(num_vcaches_lp);

  localparam int data_width_lp = 32;

  // dram address fields
  localparam int ba_width_lp = 2;
  localparam int bg_width_lp = 2;
  localparam int ro_width_lp = 6;
  localparam int co_width_lp = 5;
  localparam int bo_width_lp = 2;

  localparam int addr_width_lp =
    ba_width_lp + bg_width_lp + ro_width_lp + co_width_lp + bo_width_lp;

  // byte offset dropped, one entry per dma word
  localparam int word_addr_width_lp = addr_width_lp - bo_width_lp;
  localparam int mem_words_lp = 2 ** word_addr_width_lp;

  // reset sequencing
  localparam int tag_cycles_lp = 8;
  localparam int reset_depth_lp = 3;

  // dram timing
  localparam int read_latency_lp = 4;

  // outstanding reads tracked by the bridge, kept above the read latency
  localparam int read_fifo_depth_lp = 8;
  localparam int read_ptr_width_lp = $clog2(read_fifo_depth_lp);
  localparam int read_cnt_width_lp = $clog2(read_fifo_depth_lp + 1);

  typedef logic [vcache_id_width_lp-1:0] vcache_id_t;

  typedef logic [data_width_lp-1:0] data_t;

  // cache order, msb first: ba, bg, ro, co, bo
  typedef logic [addr_width_lp-1:0] cache_addr_t;

  // dram order, msb first: ro, bg, ba, co, bo
  typedef logic [addr_width_lp-1:0] dram_addr_t;

  typedef logic [word_addr_width_lp-1:0] dram_word_addr_t;

  typedef logic [$clog2(tag_cycles_lp)-1:0] tag_cnt_t;

  typedef logic [read_ptr_width_lp-1:0] read_ptr_t;
  typedef logic [read_cnt_width_lp-1:0] read_cnt_t;

endpackage

/* src/mc_reset_sequencer.sv */
module mc_reset_sequencer (
  input clk_i
  , input rst_i

  , output logic tag_done_o
  , output logic reset_r_o
);

  import mc_mem_pkg::*;

  tag_cnt_t tag_cnt_r;
  logic tag_done_r;

  // shift register carrying ~done toward the internal reset
  logic [reset_depth_lp-1:0] reset_chain_r;

  // tag programming phase
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tag_cnt_r <= '0;
      tag_done_r <= 1'b0;
    end
    else if (!tag_done_r) begin
      tag_cnt_r <= tag_cnt_r + 1'b1;
      // last programming cycle
      if (tag_cnt_r == tag_cnt_t'(tag_cycles_lp - 1)) begin
        tag_done_r <= 1'b1;
      end
    end
  end

  // internal reset stays asserted until done has crossed every stage
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reset_chain_r <= '1;
    end
    else begin
      reset_chain_r <= {reset_chain_r[reset_depth_lp-2:0], ~tag_done_r};
    end
  end

  assign tag_done_o = tag_done_r;
  assign reset_r_o = reset_chain_r[reset_depth_lp-1];

endmodule

/* src/mc_cache_to_dram.sv */
module mc_cache_to_dram (
  input clk_i
  , input reset_i

  // vcache dma requests
  , input logic req_v_i [mc_mem_pkg::num_vcaches_lp]
  , input logic req_write_not_read_i [mc_mem_pkg::num_vcaches_lp]
  , input mc_mem_pkg::cache_addr_t req_addr_i [mc_mem_pkg::num_vcaches_lp]
  , input mc_mem_pkg::data_t req_data_i [mc_mem_pkg::num_vcaches_lp]
  , output logic req_yumi_o [mc_mem_pkg::num_vcaches_lp]

  // read responses
  , output logic resp_v_o [mc_mem_pkg::num_vcaches_lp]
  , output mc_mem_pkg::data_t resp_data_o
  , output mc_mem_pkg::cache_addr_t resp_addr_o

  // dram request side
  , output logic dram_v_o
  , output logic dram_write_not_read_o
  , output mc_mem_pkg::dram_addr_t dram_addr_o
  , output mc_mem_pkg::data_t dram_wdata_o

  // dram read data, no back-pressure
  , input logic dram_rdata_v_i
  , input mc_mem_pkg::data_t dram_rdata_i
  , input mc_mem_pkg::dram_addr_t dram_read_done_addr_i
);

  import mc_mem_pkg::*;

  // round-robin state, last requester granted
  vcache_id_t last_r;

  logic grant_v;
  vcache_id_t grant_id;
  cache_addr_t grant_addr;

  // id fifo of accepted reads
  vcache_id_t id_fifo_mem [read_fifo_depth_lp];
  read_ptr_t wptr_r;
  read_ptr_t rptr_r;
  read_cnt_t count_r;
  logic fifo_full;
  logic fifo_empty;
  logic fifo_push;
  logic fifo_pop;
  vcache_id_t head_id;

  // address fields on the request path
  logic [ba_width_lp-1:0] req_ba;
  logic [bg_width_lp-1:0] req_bg;
  logic [ro_width_lp-1:0] req_ro;
  logic [co_width_lp-1:0] req_co;
  logic [bo_width_lp-1:0] req_bo;

  // address fields on the read-done path
  logic [ba_width_lp-1:0] rd_ba;
  logic [bg_width_lp-1:0] rd_bg;
  logic [ro_width_lp-1:0] rd_ro;
  logic [co_width_lp-1:0] rd_co;
  logic [bo_width_lp-1:0] rd_bo;

  assign fifo_full = (count_r == read_cnt_t'(read_fifo_depth_lp));
  assign fifo_empty = (count_r == '0);

  // search starts one past the last grant and wraps
  always_comb begin
    vcache_id_t idx;
    logic eligible;
    grant_v = 1'b0;
    grant_id = last_r;
    for (int i = 0; i < num_vcaches_lp; i++) begin
      req_yumi_o[i] = 1'b0;
    end
    for (int k = 1; k <= num_vcaches_lp; k++) begin
      idx = vcache_id_t'(last_r + k);
      // reads wait while the id fifo is full, writes never do
      eligible = req_v_i[idx] & (req_write_not_read_i[idx] | ~fifo_full) & ~reset_i;
      if (eligible && !grant_v) begin
        grant_v = 1'b1;
        grant_id = idx;
      end
    end
    if (grant_v) begin
      req_yumi_o[grant_id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r <= vcache_id_t'(num_vcaches_lp - 1);
    end
    else if (grant_v) begin
      last_r <= grant_id;
    end
  end

  assign grant_addr = req_addr_i[grant_id];

  assign dram_v_o = grant_v;
  assign dram_write_not_read_o = req_write_not_read_i[grant_id];
  assign dram_wdata_o = req_data_i[grant_id];

  // cache order to dram order
  assign {req_ba, req_bg, req_ro, req_co, req_bo} = grant_addr;
  assign dram_addr_o = {req_ro, req_bg, req_ba, req_co, req_bo};

  // and back again for the response
  assign {rd_ro, rd_bg, rd_ba, rd_co, rd_bo} = dram_read_done_addr_i;
  assign resp_addr_o = {rd_ba, rd_bg, rd_ro, rd_co, rd_bo};

  assign fifo_push = grant_v & ~req_write_not_read_i[grant_id];
  assign fifo_pop = dram_rdata_v_i & ~fifo_empty;
  assign head_id = id_fifo_mem[rptr_r];

  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      id_fifo_mem[wptr_r] <= grant_id;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      count_r <= '0;
    end
    else begin
      if (fifo_push) begin
        wptr_r <= wptr_r + 1'b1;
      end
      if (fifo_pop) begin
        rptr_r <= rptr_r + 1'b1;
      end
      if (fifo_push && !fifo_pop) begin
        count_r <= count_r + 1'b1;
      end
      else if (fifo_pop && !fifo_push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  // reads come back in acceptance order, so the head owns the data
  always_comb begin
    for (int i = 0; i < num_vcaches_lp; i++) begin
      resp_v_o[i] = fifo_pop & (head_id == vcache_id_t'(i));
    end
  end

  assign resp_data_o = dram_rdata_i;

endmodule

/* src/mc_test_dram.sv */
module mc_test_dram (
  input clk_i
  , input reset_i

  // one request accepted every cycle
  , input logic v_i
  , input logic write_not_read_i
  , input mc_mem_pkg::dram_addr_t addr_i
  , input mc_mem_pkg::data_t data_i

  // read data pulse
  , output logic data_v_o
  , output mc_mem_pkg::data_t data_o
  , output mc_mem_pkg::dram_addr_t read_done_addr_o
);

  import mc_mem_pkg::*;

  // contents start out cleared
  data_t mem [mem_words_lp] = '{default: '0};

  dram_word_addr_t word_addr;

  // read pipeline
  logic [read_latency_lp-1:0] rd_v_r;
  dram_addr_t rd_addr_r [read_latency_lp];
  data_t rd_data_r [read_latency_lp];

  assign word_addr = addr_i[addr_width_lp-1:bo_width_lp];

  // writes land at the accepting edge
  always_ff @(posedge clk_i) begin
    if (v_i && write_not_read_i) begin
      mem[word_addr] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_v_r <= '0;
    end
    else begin
      rd_v_r <= {rd_v_r[read_latency_lp-2:0], v_i & ~write_not_read_i};
    end
  end

  // array is sampled on entry, then carried down the stages
  always_ff @(posedge clk_i) begin
    rd_addr_r[0] <= addr_i;
    rd_data_r[0] <= mem[word_addr];
    for (int s = 1; s < read_latency_lp; s++) begin
      rd_addr_r[s] <= rd_addr_r[s-1];
      rd_data_r[s] <= rd_data_r[s-1];
    end
  end

  assign data_v_o = rd_v_r[read_latency_lp-1];
  assign data_o = rd_data_r[read_latency_lp-1];
  assign read_done_addr_o = rd_addr_r[read_latency_lp-1];

endmodule

/* src/mc_mem_harness.sv */
module mc_mem_harness (
  input clk_i
  , input rst_i

  , output logic tag_done_o

  , input logic req_v_i [mc_mem_pkg::num_vcaches_lp]
  , input logic req_write_not_read_i [mc_mem_pkg::num_vcaches_lp]
  , input mc_mem_pkg::cache_addr_t req_addr_i [mc_mem_pkg::num_vcaches_lp]
  , input mc_mem_pkg::data_t req_data_i [mc_mem_pkg::num_vcaches_lp]
  , output logic req_yumi_o [mc_mem_pkg::num_vcaches_lp]

  , output logic resp_v_o [mc_mem_pkg::num_vcaches_lp]
  , output mc_mem_pkg::data_t resp_data_o
  , output mc_mem_pkg::cache_addr_t resp_addr_o
);

  import mc_mem_pkg::*;

  logic reset_r;

  // bridge to memory
  logic dram_v;
  logic dram_write_not_read;
  dram_addr_t dram_addr;
  data_t dram_wdata;

  // memory back to bridge
  logic dram_rdata_v;
  data_t dram_rdata;
  dram_addr_t dram_read_done_addr;

  mc_reset_sequencer rst_seq (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.tag_done_o(tag_done_o)
    ,.reset_r_o(reset_r)
  );

  mc_cache_to_dram cache_to_dram (
    .clk_i(clk_i)
    ,.reset_i(reset_r)

    ,.req_v_i(req_v_i)
    ,.req_write_not_read_i(req_write_not_read_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.req_yumi_o(req_yumi_o)

    ,.resp_v_o(resp_v_o)
    ,.resp_data_o(resp_data_o)
    ,.resp_addr_o(resp_addr_o)

    ,.dram_v_o(dram_v)
    ,.dram_write_not_read_o(dram_write_not_read)
    ,.dram_addr_o(dram_addr)
    ,.dram_wdata_o(dram_wdata)

    ,.dram_rdata_v_i(dram_rdata_v)
    ,.dram_rdata_i(dram_rdata)
    ,.dram_read_done_addr_i(dram_read_done_addr)
  );

  mc_test_dram test_dram (
    .clk_i(clk_i)
    ,.reset_i(reset_r)

    ,.v_i(dram_v)
    ,.write_not_read_i(dram_write_not_read)
    ,.addr_i(dram_addr)
    ,.data_i(dram_wdata)

    ,.data_v_o(dram_rdata_v)
    ,.data_o(dram_rdata)
    ,.read_done_addr_o(dram_read_done_addr)
  );

endmodule

/* sim/mc_mem_harness_checker.sv */
module mc_mem_harness_checker (
  input clk_i
  , input reset_i
  , input logic req_v_i [mc_mem_pkg::num_vcaches_lp]
  , input logic yumi_i [mc_mem_pkg::num_vcaches_lp]
  , input logic resp_v_i [mc_mem_pkg::num_vcaches_lp]
);

  import mc_mem_pkg::*;

  logic [num_vcaches_lp-1:0] v_vec;
  logic [num_vcaches_lp-1:0] yumi_vec;
  logic [num_vcaches_lp-1:0] resp_vec;

  // assertion failures so far
  int unsigned fail_count = 0;

  always_comb begin
    for (int i = 0; i < num_vcaches_lp; i++) begin
      v_vec[i] = req_v_i[i];
      yumi_vec[i] = yumi_i[i];
      resp_vec[i] = resp_v_i[i];
    end
  end

  // at most one grant per cycle
  yumi_onehot_a: assert property (@(posedge clk_i) !reset_i |-> $onehot0(yumi_vec))
    else begin
      fail_count++;
      $error("req_yumi_o not zero or one-hot: %b", yumi_vec);
    end

  yumi_needs_v_a: assert property (@(posedge clk_i) !reset_i |-> (yumi_vec & ~v_vec) == '0)
    else begin
      fail_count++;
      $error("req_yumi_o %b without matching req_v_i %b", yumi_vec, v_vec);
    end

  resp_onehot_a: assert property (@(posedge clk_i) !reset_i |-> $onehot0(resp_vec))
    else begin
      fail_count++;
      $error("resp_v_o not zero or one-hot: %b", resp_vec);
    end

  // skip the first reset cycle, pipeline state is still unknown there
  quiet_in_reset_a: assert property (@(posedge clk_i)
    reset_i && $past(reset_i) |-> yumi_vec == '0 && resp_vec == '0)
    else begin
      fail_count++;
      $error("strobe active in reset: yumi %b resp %b", yumi_vec, resp_vec);
    end

endmodule

bind mc_cache_to_dram mc_mem_harness_checker strobe_checks (
  .clk_i(clk_i)
  ,.reset_i(reset_i)
  ,.req_v_i(req_v_i)
  ,.yumi_i(req_yumi_o)
  ,.resp_v_i(resp_v_o)
);

/* sim/mc_mem_harness_tb.sv */
module mc_mem_harness_tb;

  import mc_mem_pkg::*;

  localparam int clk_period_lp = 40;
  localparam int reset_cycles_lp = 16;
  localparam int timeout_lp = 200;

  // stimulus modes
  localparam int mode_idle_lp = 0;
  localparam int mode_mix_lp = 1;
  localparam int mode_reads_lp = 2;
  localparam int mode_writes_lp = 3;
  localparam int mode_held_lp = 4;

  logic clk_i;
  logic rst_i;
  logic tag_done_o;
  logic req_v_i [num_vcaches_lp];
  logic req_write_not_read_i [num_vcaches_lp];
  cache_addr_t req_addr_i [num_vcaches_lp];
  data_t req_data_i [num_vcaches_lp];
  logic req_yumi_o [num_vcaches_lp];
  logic resp_v_o [num_vcaches_lp];
  data_t resp_data_o;
  cache_addr_t resp_addr_o;

  // outputs as seen just before the last rising edge
  logic s_yumi [num_vcaches_lp];
  logic s_tag_done;
  int unsigned cycle;

  // reference model, keyed by cache-order word address
  data_t model [int unsigned];
  vcache_id_t exp_id_q [$];
  cache_addr_t exp_addr_q [$];
  data_t exp_data_q [$];
  int unsigned exp_due_q [$];

  vcache_id_t last_grant;
  logic have_grant;
  logic check_rr;
  logic expect_grant;
  int errors;
  int tests_run;
  int tests_failed;
  int test_start_errors;
  int unsigned assert_fails_seen;
  int waited;

  mc_mem_harness dut (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.tag_done_o(tag_done_o)
    ,.req_v_i(req_v_i)
    ,.req_write_not_read_i(req_write_not_read_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.req_yumi_o(req_yumi_o)
    ,.resp_v_o(resp_v_o)
    ,.resp_data_o(resp_data_o)
    ,.resp_addr_o(resp_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  task automatic compare_data(input string name, input data_t act, input data_t exp);
    if (act !== exp) begin
      $display("ERROR time %0t %s actual %h expected %h", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic compare_addr(input string name, input cache_addr_t act, input cache_addr_t exp);
    if (act !== exp) begin
      $display("ERROR time %0t %s actual %h expected %h", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic compare_id(input string name, input vcache_id_t act, input vcache_id_t exp);
    if (act !== exp) begin
      $display("ERROR time %0t %s actual %0d expected %0d", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERROR time %0t %s actual %b expected %b", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic compare_count(input string name, input int act, input int exp);
    if (act != exp) begin
      $display("ERROR time %0t %s actual %0d expected %0d", $time, name, act, exp);
      errors++;
    end
  endtask

  task automatic flag_problem(input string msg);
    $display("time %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic int unsigned word_of(input cache_addr_t a);
    return a[addr_width_lp-1:bo_width_lp];
  endfunction

  // 16 words spread over every field, so reads hit earlier writes
  function automatic cache_addr_t window_addr();
    logic [3:0] w;
    logic [ba_width_lp-1:0] ba;
    logic [bg_width_lp-1:0] bg;
    logic [ro_width_lp-1:0] ro;
    logic [co_width_lp-1:0] co;
    logic [bo_width_lp-1:0] bo;
    w = 4'($urandom_range(0, 15));
    ba = w[1:0];
    bg = {w[2], 1'b1};
    ro = {w[3], 5'd3};
    co = {~w[2], 4'd9};
    bo = bo_width_lp'($urandom);
    return {ba, bg, ro, co, bo};
  endfunction

  function automatic logic any_yumi();
    logic got;
    got = 1'b0;
    for (int i = 0; i < num_vcaches_lp; i++) begin
      got = got | s_yumi[i];
    end
    return got;
  endfunction

  function automatic logic any_pending();
    logic pend;
    pend = 1'b0;
    for (int i = 0; i < num_vcaches_lp; i++) begin
      pend = pend | req_v_i[i];
    end
    return pend;
  endfunction

  // sample at the rising edge, update the model, return at the falling edge
  task automatic tick();
    int act;
    int unsigned due;
    int unsigned w;
    @(posedge clk_i);
    cycle++;
    s_tag_done = tag_done_o;
    act = -1;
    for (int i = 0; i < num_vcaches_lp; i++) begin
      s_yumi[i] = req_yumi_o[i];
      if (resp_v_o[i] === 1'b1) begin
        if (act >= 0) begin
          flag_problem("two read responses in one cycle");
        end
        act = i;
      end
    end
    if (act >= 0) begin
      if (exp_id_q.size() == 0) begin
        flag_problem("read response with no read outstanding");
      end
      else begin
        compare_id("resp_v_o", vcache_id_t'(act), exp_id_q.pop_front());
        compare_addr("resp_addr_o", resp_addr_o, exp_addr_q.pop_front());
        compare_data("resp_data_o", resp_data_o, exp_data_q.pop_front());
        due = exp_due_q.pop_front();
        compare_count("read response cycle", cycle, due);
      end
    end
    else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle) begin
      flag_problem($sformatf("read response for requester %0d never came", exp_id_q[0]));
      void'(exp_id_q.pop_front());
      void'(exp_addr_q.pop_front());
      void'(exp_data_q.pop_front());
      void'(exp_due_q.pop_front());
    end
    if (expect_grant && any_pending() && !any_yumi()) begin
      flag_problem("requests pending but none granted");
    end
    for (int i = 0; i < num_vcaches_lp; i++) begin
      if (s_yumi[i] === 1'b1) begin
        w = word_of(req_addr_i[i]);
        if (req_write_not_read_i[i]) begin
          model[w] = req_data_i[i];
        end
        else begin
          exp_id_q.push_back(vcache_id_t'(i));
          exp_addr_q.push_back(req_addr_i[i]);
          exp_data_q.push_back(model.exists(w) ? model[w] : '0);
          exp_due_q.push_back(cycle + read_latency_lp);
        end
        if (check_rr && have_grant) begin
          compare_id("req_yumi_o", vcache_id_t'(i), vcache_id_t'(last_grant + 1));
        end
        last_grant = vcache_id_t'(i);
        have_grant = 1'b1;
      end
    end
    @(negedge clk_i);
  endtask

  task automatic new_request(input int i, input logic write);
    req_v_i[i] = 1'b1;
    req_write_not_read_i[i] = write;
    req_addr_i[i] = window_addr();
    req_data_i[i] = $urandom;
  endtask

  // an accepted or idle requester may take a new request, a held one keeps it
  task automatic refill(input int mode);
    for (int i = 0; i < num_vcaches_lp; i++) begin
      if (s_yumi[i] === 1'b1 || !req_v_i[i]) begin
        case (mode)
          mode_mix_lp: begin
            if ($urandom_range(0, 3) == 0) begin
              req_v_i[i] = 1'b0;
            end
            else begin
              new_request(i, $urandom_range(0, 1));
            end
          end
          mode_reads_lp: new_request(i, 1'b0);
          mode_writes_lp: new_request(i, 1'b1);
          mode_held_lp: new_request(i, $urandom_range(0, 1));
          default: req_v_i[i] = 1'b0;
        endcase
      end
    end
  endtask

  task automatic run_phase(input int mode, input int n);
    repeat (n) begin
      refill(mode);
      tick();
    end
  endtask

  task automatic drain();
    int count;
    count = 0;
    refill(mode_idle_lp);
    while ((exp_id_q.size() != 0 || any_pending()) && count < timeout_lp) begin
      tick();
      refill(mode_idle_lp);
      count++;
    end
    if (count >= timeout_lp) begin
      flag_problem("timed out waiting for outstanding requests to finish");
    end
  endtask

  task automatic begin_test();
    test_start_errors = errors;
  endtask

  task automatic end_test(input string name);
    if (dut.cache_to_dram.strobe_checks.fail_count != assert_fails_seen) begin
      flag_problem("bound strobe assertion failed");
      assert_fails_seen = dut.cache_to_dram.strobe_checks.fail_count;
    end
    tests_run++;
    if (errors == test_start_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end
    else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               errors - test_start_errors);
    end
  endtask

  initial begin
    void'($urandom(82));
    rst_i = 1'b1;
    for (int i = 0; i < num_vcaches_lp; i++) begin
      req_v_i[i] = 1'b0;
      req_write_not_read_i[i] = 1'b0;
      req_addr_i[i] = '0;
      req_data_i[i] = '0;
      s_yumi[i] = 1'b0;
    end
    cycle = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    assert_fails_seen = 0;
    have_grant = 1'b0;
    check_rr = 1'b0;
    expect_grant = 1'b0;

    begin_test();
    for (int k = 0; k < reset_cycles_lp; k++) begin
      tick();
      // flops are unknown before the first edge
      if (k > 0) begin
        compare_flag("tag_done_o", s_tag_done, 1'b0);
      end
    end
    rst_i = 1'b0;
    // every requester asks before the internal reset lets go
    refill(mode_writes_lp);
    waited = 0;
    tick();
    while (s_tag_done !== 1'b1 && waited < timeout_lp) begin
      waited++;
      tick();
    end
    if (waited >= timeout_lp) begin
      flag_problem("timed out waiting for tag_done_o");
    end
    compare_count("tag_done_o rise cycle", waited, tag_cycles_lp);
    end_test("tag programming");

    begin_test();
    waited = 0;
    while (!any_yumi() && waited < timeout_lp) begin
      waited++;
      tick();
    end
    if (waited >= timeout_lp) begin
      flag_problem("timed out waiting for the first grant");
    end
    compare_count("quiet cycles before req_yumi_o", waited, reset_depth_lp);
    expect_grant = 1'b1;
    run_phase(mode_writes_lp, 8);
    drain();
    end_test("reset release");

    begin_test();
    run_phase(mode_writes_lp, 24);
    run_phase(mode_mix_lp, 120);
    drain();
    end_test("random writes and reads");

    begin_test();
    run_phase(mode_reads_lp, 40);
    drain();
    end_test("back-to-back read latency and order");

    begin_test();
    check_rr = 1'b1;
    have_grant = 1'b0;
    run_phase(mode_held_lp, 40);
    check_rr = 1'b0;
    drain();
    end_test("round-robin grants");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end
    else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/mc_mem_pkg.sv
src/mc_reset_sequencer.sv
src/mc_cache_to_dram.sv
src/mc_test_dram.sv
src/mc_mem_harness.sv
sim/mc_mem_harness_checker.sv
sim/mc_mem_harness_tb.sv
